//--- Bender.yml
package:
  name: slot_store

sources:
  # Design sources in compile order
  - include_dirs:
      - rtl
    files:
      - rtl/slot_pkg.sv
      - rtl/entry_ram.sv
      - rtl/slot_heap.sv
      - rtl/record_stamper.sv
      - rtl/record_drain.sv
      - rtl/slot_store_top.sv

  # Testbench sources
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/slot_store_clock.sv
      - dv/slot_store_properties.sv
      - dv/slot_store_tb.sv

//--- dv/slot_store_clock.sv
// ==============================
// Testbench clock and reset
// Free-running clock, synchronous reset held for a few cycles
// ==============================

`timescale 1ns/10ps

module slot_store_clock
#(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
)
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset released on a falling edge, like the other stimulus
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- dv/slot_store_properties.sv
// ==============================
// Slot store properties
// Concurrent checks on the top level strobes
// ==============================

`timescale 1ns/10ps

`include "slot_config.svh"

module slot_store_properties
(
    input logic clk,
    input logic reset,
    input logic in_valid,
    input logic in_ready,
    input logic drain,
    input logic out_valid,
    input logic alloc,
    input logic push,
    input logic release_en
);

    // Shadow of the consumer index FIFO fill level
    logic [$clog2(`SLOT_COUNT + 1)-1:0] fifo_level;

    // Number of failed assertions, read by the testbench
    int fail_count = 0;

    always_ff @(posedge clk)
    begin
        if (reset)
            fifo_level <= '0;
        else if (push && !release_en)
            fifo_level <= fifo_level + 1'b1;
        else if (release_en && !push)
            fifo_level <= fifo_level - 1'b1;
    end

    // Back-to-back outputs need a drain in each of the two cycles before
    out_valid_pair: assert property (@(posedge clk) disable iff (reset)
        (out_valid && $past(out_valid)) |-> ($past(drain) && $past(drain, 2)))
    else
    begin
        fail_count++;
        $error("out_valid twice in a row without two drains");
    end

    // Accepted input always allocates
    accept_allocs: assert property (@(posedge clk) disable iff (reset)
        (in_valid && in_ready) |-> alloc)
    else
    begin
        fail_count++;
        $error("accepted input without a heap allocation");
    end

    // No slot returned from an empty FIFO
    release_nonempty: assert property (@(posedge clk) disable iff (reset)
        release_en |-> (fifo_level != '0))
    else
    begin
        fail_count++;
        $error("slot released while the index FIFO is empty");
    end

endmodule

//--- dv/slot_store_tb.sv
// ==============================
// Slot store testbench
// Random fill and drain bursts checked against a queue model
// ==============================

`timescale 1ns/10ps

`include "slot_config.svh"

module slot_store_tb;

    localparam int PERIOD_NS     = 100;
    localparam int CAPACITY      = `SLOT_COUNT - 2 - `MIN_FREE_SLOTS;
    localparam int STIM_CYCLES   = 6000;
    localparam int MARGIN_CYCLES = 200;
    localparam longint TIMEOUT_NS =
        longint'(STIM_CYCLES + `SLOT_COUNT + MARGIN_CYCLES) * PERIOD_NS;

    logic                     clk;
    logic                     reset;
    logic                     in_valid;
    logic [`PAYLOAD_BITS-1:0] in_payload;
    logic                     in_ready;
    logic                     drain;
    logic                     out_valid;
    slot_pkg::record_t        out_rec;

    // ==============================
    // Reference model state
    // ==============================

    slot_pkg::record_t    exp_q[$];
    logic [`SEQ_BITS-1:0] exp_seq;
    logic                 exp_valid;
    slot_pkg::record_t    exp_rec;

    integer seed;
    int     rise_cycles;
    int     cycles;
    int     mode;
    int     burst_len;
    logic   v;
    logic   d;

    slot_store_clock
    #(
        .PERIOD_NS    (PERIOD_NS),
        .RESET_CYCLES (10)
    )
    clock_inst
    (
        .clk   (clk),
        .reset (reset)
    );

    slot_store_top slot_store_top_inst
    (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_payload (in_payload),
        .in_ready   (in_ready),
        .drain      (drain),
        .out_valid  (out_valid),
        .out_rec    (out_rec)
    );

    bind slot_store_top slot_store_properties properties_inst
    (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .drain      (drain),
        .out_valid  (out_valid),
        .alloc      (alloc),
        .push       (push),
        .release_en (release_en)
    );

    // Compare one value, stop on the first mismatch
    task automatic check_equal(input string what, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected)
        begin
            $display("ERROR at %0t ns: %s mismatch, got %h expected %h",
                     $time, what, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // One cycle: check last cycle's output, then drive and update the model
    task automatic run_cycle(input logic valid_in, input logic drain_in);
        slot_pkg::record_t rec;
        @(negedge clk);
        check_equal("assertion failures", slot_store_top_inst.properties_inst.fail_count, 0);
        check_equal("out_valid", out_valid, exp_valid);
        if (exp_valid)
        begin
            check_equal("out_rec.seq", out_rec.seq, exp_rec.seq);
            check_equal("out_rec.payload", out_rec.payload, exp_rec.payload);
        end
        // Full heap must hold off the producer
        if (exp_q.size() == CAPACITY)
            check_equal("in_ready at capacity", in_ready, 1'b0);

        in_valid   = valid_in;
        in_payload = $random(seed);
        drain      = drain_in;

        // FIFO count is registered, so a same-cycle push cannot be drained
        exp_valid = drain_in && (exp_q.size() != 0);
        if (exp_valid)
            exp_rec = exp_q.pop_front();

        // in_ready is stable until the next rising edge
        if (valid_in && in_ready)
        begin
            rec.seq     = exp_seq;
            rec.payload = in_payload;
            exp_q.push_back(rec);
            exp_seq = exp_seq + 1'b1;
        end
    endtask

    // ==============================
    // Watchdog
    // ==============================

    initial
    begin
        #(TIMEOUT_NS);
        $display("Watchdog expired at %0t ns before the test sequence finished", $time);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog timeout");
    end

    // ==============================
    // Stimulus
    // ==============================

    initial
    begin
        seed        = 32'h2f15d97b;
        in_valid    = 1'b0;
        in_payload  = '0;
        drain       = 1'b0;
        exp_seq     = '0;
        exp_valid   = 1'b0;
        exp_rec     = '0;

        @(negedge reset);

        // Sweep keeps in_ready low for a bounded stretch
        rise_cycles = 0;
        while (!in_ready && rise_cycles < `SLOT_COUNT + 2)
        begin
            @(negedge clk);
            rise_cycles++;
        end
        check_equal("in_ready low during sweep", (rise_cycles - 1) >= (`SLOT_COUNT - 3), 1'b1);
        check_equal("in_ready high after sweep", in_ready, 1'b1);

        // Fill only, a few strobes past capacity are dropped
        repeat (CAPACITY + 3) run_cycle(1'b1, 1'b0);
        run_cycle(1'b0, 1'b0);
        check_equal("occupancy after fill", exp_q.size(), CAPACITY);
        check_equal("in_ready after fill", in_ready, 1'b0);

        // Drain past empty, the extra drains give no output
        repeat (CAPACITY + 4) run_cycle(1'b0, 1'b1);

        // Random bursts leaning toward fill, drain or a mix
        cycles = 0;
        while (cycles < STIM_CYCLES)
        begin
            mode      = $unsigned($random(seed)) % 4;
            burst_len = 4 + ($unsigned($random(seed)) % 16);
            repeat (burst_len)
            begin
                case (mode)
                    0:
                    begin
                        v = ($unsigned($random(seed)) % 8) != 0;
                        d = ($unsigned($random(seed)) % 8) == 0;
                    end
                    1:
                    begin
                        v = ($unsigned($random(seed)) % 8) == 0;
                        d = ($unsigned($random(seed)) % 8) != 0;
                    end
                    default:
                    begin
                        v = $random(seed);
                        d = $random(seed);
                    end
                endcase
                run_cycle(v, d);
                cycles++;
            end
        end

        // Empty the store and check the last output
        repeat (CAPACITY + 2) run_cycle(1'b0, 1'b1);
        run_cycle(1'b0, 1'b0);

        // All slots back in the heap, so the producer is let in again
        check_equal("in_ready after drain", in_ready, 1'b1);

        // One more edge for the bound assertions
        @(negedge clk);
        if (slot_store_top_inst.properties_inst.fail_count == 0)
        begin
            $display("RESULT: PASS");
            $finish;
        end
        else
        begin
            $display("Bound assertion failed in the last cycle");
            $display("RESULT: FAIL");
            $fatal(1, "assertion failure");
        end
    end

endmodule

//--- rtl/entry_ram.sv
// ==============================
// Entry RAM
// Simple dual-port memory, one write and one read port,
// read data registered, word type set by a type parameter
// ==============================

`timescale 1ns/10ps

module entry_ram
#(
    parameter int DEPTH = 16,
    parameter type entry_t = logic
)
(
    input  logic                clk,

    // Write port
    input  logic                wen,
    input  slot_pkg::slot_idx_t waddr,
    input  entry_t              wdata,

    // Read port, data one cycle after the address
    input  slot_pkg::slot_idx_t raddr,
    output entry_t              rdata
);

    // Storage, no reset
    entry_t mem [DEPTH];

    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            mem[waddr] <= wdata;
        end

        // Old contents returned on a same-address write
        rdata <= mem[raddr];
    end

endmodule

//--- rtl/record_drain.sv
// ==============================
// Record drain
// Keeps allocated slots in arrival order, reads the oldest
// on a drain strobe and hands the slot back to the heap
// ==============================

`timescale 1ns/10ps

`include "slot_config.svh"

module record_drain
(
    input  logic                clk,
    input  logic                reset,

    // Slot index from the producer side
    input  logic                push,
    input  slot_pkg::slot_idx_t push_idx,

    // Drain request
    input  logic                drain,

    // Heap read
    output slot_pkg::slot_idx_t read_idx,
    input  slot_pkg::record_t   read_rec,

    // Heap release, same cycle as the read
    output logic                release_en,
    output slot_pkg::slot_idx_t release_idx,

    // Output side
    output logic                out_valid,
    output slot_pkg::record_t   out_rec
);

    localparam int DEPTH = `SLOT_COUNT;

    // ==============================
    // Index FIFO
    // ==============================

    slot_pkg::slot_idx_t        fifo_mem [DEPTH];
    slot_pkg::slot_idx_t        wr_ptr;
    slot_pkg::slot_idx_t        rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] fifo_count;
    logic                       pop;

    // Drain on an empty FIFO is ignored
    assign pop = drain && (fifo_count != '0);

    // Oldest slot read straight from the FIFO head
    assign read_idx    = fifo_mem[rd_ptr];
    assign release_en  = pop;
    assign release_idx = read_idx;

    // Heap read data arrives with out_valid
    assign out_rec = read_rec;

    always_ff @(posedge clk)
    begin
        if (push)
            fifo_mem[wr_ptr] <= push_idx;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
            out_valid  <= 1'b0;
        end
        else
        begin
            // One cycle read latency of the heap
            out_valid <= pop;

            if (push)
                wr_ptr <= (wr_ptr == slot_pkg::slot_idx_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == slot_pkg::slot_idx_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

            // Push and pop together keep the count
            case ({push, pop})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
        end
    end

endmodule

//--- rtl/record_stamper.sv
// ==============================
// Record stamper
// Accepts input strobes, stamps a running sequence number
// and issues the heap allocation and the index push
// ==============================

`timescale 1ns/10ps

`include "slot_config.svh"

module record_stamper
(
    input  logic                     clk,
    input  logic                     reset,

    // Input side
    input  logic                     in_valid,
    input  logic [`PAYLOAD_BITS-1:0] in_payload,

    // To heap
    output logic                     alloc,
    output slot_pkg::record_t        alloc_rec,

    // To consumer
    output logic                     push,

    // Heap not-full level
    input  logic                     ready
);

    // Running stamp, wraps naturally
    logic [`SEQ_BITS-1:0] seq_cnt;

    // Strobes while not ready are dropped
    assign alloc = in_valid && ready;

    // Index push goes with the allocation
    assign push = alloc;

    assign alloc_rec.seq     = seq_cnt;
    assign alloc_rec.payload = in_payload;

    always_ff @(posedge clk)
    begin
        if (reset)
            seq_cnt <= '0;
        else if (alloc)
            seq_cnt <= seq_cnt + 1'b1;
    end

endmodule

//--- rtl/slot_config.svh
// ==============================
// Slot store configuration
// Sizes of the heap, the full threshold and the record fields
// ==============================

`ifndef SLOT_CONFIG_SVH
`define SLOT_CONFIG_SVH

// Number of heap slots, at least MIN_FREE_SLOTS plus 3
`define SLOT_COUNT 16

// Heap reports full at or below this many free slots
`define MIN_FREE_SLOTS 1

// Record field widths
`define PAYLOAD_BITS 32
`define SEQ_BITS 8

`endif

//--- rtl/slot_heap.sv
// ==============================
// Slot heap
// Record storage with a two-head round-robin free list,
// initialization sweep after reset and a registered not-full level
// ==============================

`timescale 1ns/10ps

`include "slot_config.svh"

module slot_heap
(
    input  logic                clk,
    input  logic                reset,

    // Allocation, slot index answered in the same cycle
    input  logic                alloc,
    input  slot_pkg::record_t   alloc_rec,
    output slot_pkg::slot_idx_t alloc_idx,
    output logic                not_full,

    // Read, record returned one cycle later
    input  slot_pkg::slot_idx_t read_idx,
    output slot_pkg::record_t   read_rec,

    // Slot return
    input  logic                release_en,
    input  slot_pkg::slot_idx_t release_idx
);

    // ==============================
    // Record storage
    // ==============================

    // Written in the allocation cycle
    entry_ram
    #(
        .DEPTH   (`SLOT_COUNT),
        .entry_t (slot_pkg::record_t)
    )
    data_ram
    (
        .clk   (clk),
        .wen   (alloc),
        .waddr (alloc_idx),
        .wdata (alloc_rec),
        .raddr (read_idx),
        .rdata (read_rec)
    );

    // ==============================
    // Free list
    // ==============================

    // Two list heads hide the two-cycle next-pointer lookup
    slot_pkg::slot_idx_t [1:0] free_head;
    slot_pkg::slot_idx_t [1:0] free_head_reg;
    slot_pkg::slot_idx_t [1:0] free_tail;
    logic                      head_sel;
    logic                      tail_sel;

    // Next-pointer memory signals
    logic                      free_wen;
    slot_pkg::slot_idx_t       free_wdata;
    slot_pkg::slot_idx_t       free_next;
    slot_pkg::slot_idx_t       free_next_q;

    // Pop tracking
    logic                      alloc_q;
    logic                      alloc_qq;
    logic                      head_sel_q;
    logic                      head_sel_qq;

    // Delayed release
    logic                      release_q;
    slot_pkg::slot_idx_t       release_idx_q;

    // Sweep and free count
    logic                      init_done;
    slot_pkg::slot_idx_t       init_idx;
    slot_pkg::slot_idx_t       num_free;

    // Slot taken this cycle
    assign alloc_idx = free_head[head_sel];

    entry_ram
    #(
        .DEPTH   (`SLOT_COUNT),
        .entry_t (slot_pkg::slot_idx_t)
    )
    free_ram
    (
        .clk   (clk),
        .wen   (free_wen),
        .waddr (free_tail[tail_sel]),
        .wdata (free_wdata),
        .raddr (alloc_idx),
        .rdata (free_next)
    );

    // Head of a popped list is replaced two cycles after the pop
    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            if (alloc_qq && (head_sel_qq == 1'(i)))
                free_head[i] = free_next_q;
            else
                free_head[i] = free_head_reg[i];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            alloc_q          <= 1'b0;
            alloc_qq         <= 1'b0;
            head_sel         <= 1'b0;
            head_sel_q       <= 1'b0;
            head_sel_qq      <= 1'b0;
            // Slots 0 and 1 start as the list heads
            free_head_reg[0] <= slot_pkg::slot_idx_t'(0);
            free_head_reg[1] <= slot_pkg::slot_idx_t'(1);
        end
        else
        begin
            alloc_q       <= alloc;
            alloc_qq      <= alloc_q;
            head_sel_q    <= head_sel;
            head_sel_qq   <= head_sel_q;
            free_head_reg <= free_head;
            // Alternate lists on every pop
            if (alloc)
                head_sel <= ~head_sel;
        end
    end

    // Extra stage on the next-pointer read
    always_ff @(posedge clk)
    begin
        free_next_q <= free_next;
    end

    // Returned slot pushed one cycle late
    always_ff @(posedge clk)
    begin
        if (reset)
            release_q <= 1'b0;
        else
            release_q <= release_en;

        release_idx_q <= release_idx;
    end

    // Sweep writes slots 2 and up, then only released slots
    assign free_wen   = !init_done || release_q;
    assign free_wdata = init_done ? release_idx_q : init_idx;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            free_tail[0] <= slot_pkg::slot_idx_t'(0);
            free_tail[1] <= slot_pkg::slot_idx_t'(1);
            tail_sel     <= 1'b0;
        end
        else if (free_wen)
        begin
            // Pushed slot becomes the new tail, next push on the other list
            free_tail[tail_sel] <= free_wdata;
            tail_sel            <= ~tail_sel;
        end
    end

    // ==============================
    // Sweep and free count
    // ==============================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            init_idx  <= slot_pkg::slot_idx_t'(2);
            init_done <= 1'b0;
            num_free  <= '0;
            not_full  <= 1'b0;
        end
        else if (!init_done)
        begin
            init_idx <= init_idx + 1'b1;
            if (init_idx == slot_pkg::slot_idx_t'(`SLOT_COUNT - 1))
            begin
                init_done <= 1'b1;
                // Two slots always stay listed so neither head runs dry
                num_free  <= slot_pkg::slot_idx_t'(`SLOT_COUNT - 2);
                not_full  <= (`SLOT_COUNT - 2) > `MIN_FREE_SLOTS;
            end
        end
        else if (release_q && !alloc)
        begin
            num_free <= num_free + 1'b1;
            not_full <= (num_free + 1'b1) > slot_pkg::slot_idx_t'(`MIN_FREE_SLOTS);
            assert (num_free < slot_pkg::slot_idx_t'(`SLOT_COUNT - 2))
            else $error("slot_heap: slot released twice");
        end
        else if (alloc && !release_q)
        begin
            num_free <= num_free - 1'b1;
            not_full <= (num_free - 1'b1) > slot_pkg::slot_idx_t'(`MIN_FREE_SLOTS);
            assert (num_free != '0)
            else $error("slot_heap: allocation from an empty heap");
        end
        // Alloc and release together leave the count alone
    end

endmodule

//--- rtl/slot_pkg.sv
// ==============================
// Slot store types
// Slot index and stored record shared by producer, heap and consumer
// ==============================

`include "slot_config.svh"

package slot_pkg;

    // Index of one heap slot
    typedef logic [$clog2(`SLOT_COUNT)-1:0] slot_idx_t;

    // One stored word, sequence stamp above the payload
    typedef struct packed {
        logic [`SEQ_BITS-1:0]     seq;
        logic [`PAYLOAD_BITS-1:0] payload;
    } record_t;

endpackage

//--- rtl/slot_store_top.sv
// ==============================
// Slot store top level
// Producer, slot heap and consumer joined by wires
// ==============================

`timescale 1ns/10ps

`include "slot_config.svh"

module slot_store_top
(
    input  logic                     clk,
    input  logic                     reset,

    input  logic                     in_valid,
    input  logic [`PAYLOAD_BITS-1:0] in_payload,
    output logic                     in_ready,

    input  logic                     drain,
    output logic                     out_valid,
    output slot_pkg::record_t        out_rec
);

    // Producer to heap and consumer
    logic                alloc;
    slot_pkg::record_t   alloc_rec;
    slot_pkg::slot_idx_t alloc_idx;
    logic                push;

    // Consumer to heap
    slot_pkg::slot_idx_t read_idx;
    slot_pkg::record_t   read_rec;
    logic                release_en;
    slot_pkg::slot_idx_t release_idx;

    record_stamper stamper_inst
    (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_payload (in_payload),
        .alloc      (alloc),
        .alloc_rec  (alloc_rec),
        .push       (push),
        .ready      (in_ready)
    );

    // Heap not-full level is the input ready
    slot_heap heap_inst
    (
        .clk         (clk),
        .reset       (reset),
        .alloc       (alloc),
        .alloc_rec   (alloc_rec),
        .alloc_idx   (alloc_idx),
        .not_full    (in_ready),
        .read_idx    (read_idx),
        .read_rec    (read_rec),
        .release_en  (release_en),
        .release_idx (release_idx)
    );

    // Allocated slot pushed in the allocation cycle
    record_drain drain_inst
    (
        .clk         (clk),
        .reset       (reset),
        .push        (push),
        .push_idx    (alloc_idx),
        .drain       (drain),
        .read_idx    (read_idx),
        .read_rec    (read_rec),
        .release_en  (release_en),
        .release_idx (release_idx),
        .out_valid   (out_valid),
        .out_rec     (out_rec)
    );

endmodule

//--- sim.f
+incdir+rtl
rtl/slot_pkg.sv
rtl/entry_ram.sv
rtl/slot_heap.sv
rtl/record_stamper.sv
rtl/record_drain.sv
rtl/slot_store_top.sv
dv/slot_store_clock.sv
dv/slot_store_properties.sv
dv/slot_store_tb.sv
